/* design/rv32_decode_params.svh */
`ifndef RV32_DECODE_PARAMS_SVH
`define RV32_DECODE_PARAMS_SVH

// Datapath and index widths
`define DATA_WIDTH     32
`define REG_IDX_WIDTH  5
`define CB_IDX_WIDTH   4

// Encodings the decoder matches on
`define HALT_WORD      32'hFFFF_FFFF
`define FUNCT7_MULDIV  7'b0000001
`define FUNCT3_FENCE_I 3'b001

// Byte distance to the next sequential instruction
`define INSTR_BYTES    32'd4

`endif

/* design/rv32_isa_pkg.sv */
`include "rv32_decode_params.svh"

package rv32_isa_pkg;

  typedef logic [`DATA_WIDTH-1:0] word_t;
  typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

  // Major opcodes handled by this decode stage
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    MISCMEM = 7'b0001111
  } opcode_e;

  typedef logic [2:0] funct3_t;

  // Width and signedness of a memory access, straight from funct3
  typedef logic [2:0] load_type_t;

endpackage

/* design/decode_ctrl_pkg.sv */
`include "rv32_decode_params.svh"

package decode_ctrl_pkg;

  typedef enum logic [1:0] {
    ARITH     = 2'd0,
    MULT      = 2'd1,
    LOADSTORE = 2'd2
  } fu_type_e;

  // Operand A source
  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } src_a_sel_e;

  // Operand B source
  typedef enum logic [1:0] {
    B_RS2,
    B_IMM_I,
    B_IMM_S,
    B_IMM_U
  } src_b_sel_e;

  // Write-back data produced in decode
  typedef enum logic [1:0] {
    W_ALU,
    W_PC4,
    W_IMM_U
  } w_src_e;

  // {instr[30], funct3}
  typedef logic [3:0] alu_op_t;

  typedef logic [`CB_IDX_WIDTH-1:0] cb_index_t;

endpackage

/* design/decode_ctrl_if.sv */
`timescale 1ns/1ps
`include "rv32_decode_params.svh"

interface decode_ctrl_if;
  rv32_isa_pkg::reg_idx_t      rs1, rs2, rd;
  decode_ctrl_pkg::fu_type_e   fu_type;
  logic                        arith_ena, mult_ena, ls_ena;
  decode_ctrl_pkg::alu_op_t    alu_op;
  decode_ctrl_pkg::w_src_e     w_src;
  logic                        wen;
  logic                        mult_high, mult_signed;
  logic                        dren, dwen;
  rv32_isa_pkg::load_type_t    load_type;
  logic                        jump, j_sel;
  logic [11:0]                 imm_i, imm_s;
  rv32_isa_pkg::word_t         imm_u;
  logic [20:0]                 imm_j;
  decode_ctrl_pkg::src_a_sel_e src_a_sel;
  decode_ctrl_pkg::src_b_sel_e src_b_sel;
  logic                        ifence, halt;

  modport decoder (
    output rs1, rs2, rd, fu_type, arith_ena, mult_ena, ls_ena, alu_op, w_src, wen,
    output mult_high, mult_signed, dren, dwen, load_type, jump, j_sel,
    output imm_i, imm_s, imm_u, imm_j, src_a_sel, src_b_sel, ifence, halt
  );

  modport operands (
    input src_a_sel, src_b_sel, w_src, j_sel, imm_i, imm_s, imm_u, imm_j
  );

  modport fence (
    input ifence
  );

  modport latch (
    input rd, fu_type, arith_ena, mult_ena, ls_ena, alu_op, wen, mult_high, mult_signed,
    input dren, dwen, load_type, jump, halt
  );

endinterface

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`include "rv32_decode_params.svh"

module instr_decoder (
  input rv32_isa_pkg::word_t instr,
  decode_ctrl_if.decoder     ctrl
);

  rv32_isa_pkg::opcode_e opcode;
  rv32_isa_pkg::funct3_t funct3;
  logic [6:0]            funct7;

  assign opcode = rv32_isa_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Fixed-position fields
  assign ctrl.rs1 = instr[19:15];
  assign ctrl.rs2 = instr[24:20];
  assign ctrl.rd  = instr[11:7];

  assign ctrl.imm_i = instr[31:20];
  assign ctrl.imm_s = {instr[31:25], instr[11:7]};
  assign ctrl.imm_u = {instr[31:12], 12'b0};
  assign ctrl.imm_j = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign ctrl.load_type = funct3;

  // MULH, MULHSU and MULHU return the upper half
  assign ctrl.mult_high   = |funct3[1:0];
  // Only MULHU treats rs1 as unsigned
  assign ctrl.mult_signed = ~(funct3[1] & funct3[0]);

  always_comb begin
    ctrl.fu_type   = decode_ctrl_pkg::ARITH;
    ctrl.arith_ena = 1'b0;
    ctrl.mult_ena  = 1'b0;
    ctrl.ls_ena    = 1'b0;
    ctrl.alu_op    = '0;
    ctrl.w_src     = decode_ctrl_pkg::W_ALU;
    ctrl.wen       = 1'b0;
    ctrl.dren      = 1'b0;
    ctrl.dwen      = 1'b0;
    ctrl.jump      = 1'b0;
    ctrl.j_sel     = 1'b0;
    ctrl.src_a_sel = decode_ctrl_pkg::A_RS1;
    ctrl.src_b_sel = decode_ctrl_pkg::B_RS2;
    ctrl.ifence    = 1'b0;
    ctrl.halt      = 1'b0;

    if (instr == `HALT_WORD) begin
      ctrl.halt = 1'b1;
    end else begin
      case (opcode)
        rv32_isa_pkg::LUI: begin
          ctrl.arith_ena = 1'b1;
          ctrl.wen       = 1'b1;
          ctrl.w_src     = decode_ctrl_pkg::W_IMM_U;
          ctrl.src_a_sel = decode_ctrl_pkg::A_ZERO;
          ctrl.src_b_sel = decode_ctrl_pkg::B_IMM_U;
        end
        rv32_isa_pkg::AUIPC: begin
          ctrl.arith_ena = 1'b1;
          ctrl.wen       = 1'b1;
          ctrl.src_a_sel = decode_ctrl_pkg::A_PC;
          ctrl.src_b_sel = decode_ctrl_pkg::B_IMM_U;
        end
        rv32_isa_pkg::JAL, rv32_isa_pkg::JALR: begin
          ctrl.arith_ena = 1'b1;
          ctrl.wen       = 1'b1;
          ctrl.w_src     = decode_ctrl_pkg::W_PC4;
          ctrl.jump      = 1'b1;
          ctrl.j_sel     = (opcode == rv32_isa_pkg::JAL);
        end
        rv32_isa_pkg::IMMED: begin
          ctrl.arith_ena = 1'b1;
          ctrl.wen       = 1'b1;
          ctrl.src_b_sel = decode_ctrl_pkg::B_IMM_I;
          // Bit 30 only matters for SRAI, it is immediate data elsewhere
          ctrl.alu_op    = {(funct3 == 3'b101) & instr[30], funct3};
        end
        rv32_isa_pkg::REGREG: begin
          if (funct7 == `FUNCT7_MULDIV) begin
            // Divide forms decode to no unit
            if (!funct3[2]) begin
              ctrl.fu_type  = decode_ctrl_pkg::MULT;
              ctrl.mult_ena = 1'b1;
              ctrl.wen      = 1'b1;
            end
          end else begin
            ctrl.arith_ena = 1'b1;
            ctrl.wen       = 1'b1;
            ctrl.alu_op    = {instr[30], funct3};
          end
        end
        rv32_isa_pkg::LOAD: begin
          ctrl.fu_type   = decode_ctrl_pkg::LOADSTORE;
          ctrl.ls_ena    = 1'b1;
          ctrl.wen       = 1'b1;
          ctrl.dren      = 1'b1;
          ctrl.src_b_sel = decode_ctrl_pkg::B_IMM_I;
        end
        rv32_isa_pkg::STORE: begin
          ctrl.fu_type   = decode_ctrl_pkg::LOADSTORE;
          ctrl.ls_ena    = 1'b1;
          ctrl.dwen      = 1'b1;
          ctrl.src_b_sel = decode_ctrl_pkg::B_IMM_S;
        end
        rv32_isa_pkg::MISCMEM: begin
          ctrl.ifence = (funct3 == `FUNCT3_FENCE_I);
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* design/operand_select.sv */
`timescale 1ns/1ps
`include "rv32_decode_params.svh"

module operand_select (
  decode_ctrl_if.operands     ctrl,
  input  rv32_isa_pkg::word_t pc,
  input  rv32_isa_pkg::word_t rs1_data,
  input  rv32_isa_pkg::word_t rs2_data,
  output rv32_isa_pkg::word_t port_a,
  output rv32_isa_pkg::word_t port_b,
  output rv32_isa_pkg::word_t wdata,
  output rv32_isa_pkg::word_t j_base,
  output rv32_isa_pkg::word_t j_offset
);

  rv32_isa_pkg::word_t imm_i_ext, imm_s_ext, imm_j_ext;
  rv32_isa_pkg::word_t pc4;

  assign imm_i_ext = {{(`DATA_WIDTH-12){ctrl.imm_i[11]}}, ctrl.imm_i};
  assign imm_s_ext = {{(`DATA_WIDTH-12){ctrl.imm_s[11]}}, ctrl.imm_s};
  assign imm_j_ext = {{(`DATA_WIDTH-21){ctrl.imm_j[20]}}, ctrl.imm_j};

  assign pc4 = pc + `INSTR_BYTES;

  always_comb begin
    case (ctrl.src_a_sel)
      decode_ctrl_pkg::A_PC:   port_a = pc;
      decode_ctrl_pkg::A_ZERO: port_a = '0;
      default:                 port_a = rs1_data;
    endcase
  end

  always_comb begin
    case (ctrl.src_b_sel)
      decode_ctrl_pkg::B_IMM_I: port_b = imm_i_ext;
      decode_ctrl_pkg::B_IMM_S: port_b = imm_s_ext;
      decode_ctrl_pkg::B_IMM_U: port_b = ctrl.imm_u;
      default:                  port_b = rs2_data;
    endcase
  end

  // Link value for jumps, upper immediate for LUI
  always_comb begin
    case (ctrl.w_src)
      decode_ctrl_pkg::W_PC4:   wdata = pc4;
      decode_ctrl_pkg::W_IMM_U: wdata = ctrl.imm_u;
      default:                  wdata = '0;
    endcase
  end

  // JAL is pc relative, JALR adds imm_i to rs1
  assign j_base   = ctrl.j_sel ? pc : port_a;
  assign j_offset = ctrl.j_sel ? imm_j_ext : imm_i_ext;

endmodule

/* design/fence_tracker.sv */
`timescale 1ns/1ps
`include "rv32_decode_params.svh"

module fence_tracker (
  input  logic          CLK,
  input  logic          nRST,
  decode_ctrl_if.fence  ctrl,
  input  logic          pc_en,
  input  logic          iflush_done,
  input  logic          dflush_done,
  output logic          icache_flush,
  output logic          dcache_flush,
  output logic          iflushed,
  output logic          dflushed
);

  logic       fence_reg;
  logic       flush_pulse;
  logic [1:0] done;
  logic [1:0] flushed;

  // Rising edge of ifence, back-to-back FENCE.I give one pulse
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fence_reg <= 1'b0;
    end else if (pc_en) begin
      fence_reg <= ctrl.ifence;
    end
  end

  assign flush_pulse  = ctrl.ifence & ~fence_reg;
  assign icache_flush = flush_pulse;
  assign dcache_flush = flush_pulse;

  // Bit 0 tracks the I-cache, bit 1 the D-cache
  assign done = {dflush_done, iflush_done};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      flushed <= 2'b11;
    end else if (flush_pulse) begin
      flushed <= 2'b00;
    end else begin
      flushed <= flushed | (done & {2{pc_en}});
    end
  end

  assign iflushed = flushed[0];
  assign dflushed = flushed[1];

endmodule

/* design/issue_latch.sv */
`timescale 1ns/1ps
`include "rv32_decode_params.svh"

module issue_latch (
  input  logic                        CLK,
  input  logic                        nRST,
  decode_ctrl_if.latch                ctrl,
  input  logic                        flush,
  input  logic                        stall_fetch_decode,
  input  logic                        stall_ex,
  input  logic                        stall_arith,
  input  logic                        stall_mult,
  input  logic                        stall_ls,
  input  decode_ctrl_pkg::cb_index_t  cb_tail,
  input  rv32_isa_pkg::word_t         pc,
  input  rv32_isa_pkg::word_t         port_a, port_b, wdata, j_base, j_offset,
  input  rv32_isa_pkg::word_t         rs2_data,
  // Arithmetic unit
  output logic                        arith_ena,
  output decode_ctrl_pkg::alu_op_t    alu_op,
  output logic                        arith_wen,
  output rv32_isa_pkg::reg_idx_t      arith_rd,
  output decode_ctrl_pkg::cb_index_t  arith_index,
  output rv32_isa_pkg::word_t         ex_wdata,
  output logic                        jump_instr,
  output rv32_isa_pkg::word_t         ex_j_base, ex_j_offset,
  // Multiply unit
  output logic                        mult_ena, mult_high, mult_signed,
  output rv32_isa_pkg::reg_idx_t      mult_rd,
  output decode_ctrl_pkg::cb_index_t  mult_index,
  // Load/store unit
  output logic                        ls_ena, ls_dren, ls_dwen,
  output rv32_isa_pkg::load_type_t    ls_load_type,
  output rv32_isa_pkg::reg_idx_t      ls_rd,
  output decode_ctrl_pkg::cb_index_t  ls_index,
  output rv32_isa_pkg::word_t         store_data,
  // Shared
  output rv32_isa_pkg::word_t         ex_port_a, ex_port_b, ex_pc,
  output decode_ctrl_pkg::fu_type_e   ex_fu_type,
  output logic                        halt_instr,
  output logic                        busy_decode
);

  logic issue_flush;
  logic any_unit_stall;

  // Decode held while execute moves on, so a bubble goes down
  assign issue_flush    = flush | (stall_fetch_decode & ~stall_ex);
  assign any_unit_stall = stall_arith | stall_mult | stall_ls;
  assign busy_decode    = ctrl.halt & any_unit_stall;

  // Arithmetic unit fields, held under back-pressure
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      arith_ena   <= 1'b0;
      alu_op      <= '0;
      arith_wen   <= 1'b0;
      arith_rd    <= '0;
      arith_index <= '0;
      ex_wdata    <= '0;
      jump_instr  <= 1'b0;
      ex_j_base   <= '0;
      ex_j_offset <= '0;
    end else if (issue_flush || !ctrl.arith_ena) begin
      arith_ena   <= 1'b0;
      alu_op      <= '0;
      arith_wen   <= 1'b0;
      arith_rd    <= '0;
      arith_index <= '0;
      ex_wdata    <= '0;
      jump_instr  <= 1'b0;
      ex_j_base   <= '0;
      ex_j_offset <= '0;
    end else if (!stall_arith) begin
      arith_ena   <= 1'b1;
      alu_op      <= ctrl.alu_op;
      arith_wen   <= ctrl.wen;
      arith_rd    <= ctrl.rd;
      arith_index <= cb_tail;
      ex_wdata    <= wdata;
      jump_instr  <= ctrl.jump;
      ex_j_base   <= j_base;
      ex_j_offset <= j_offset;
    end
  end

  // Multiply unit fields
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mult_ena    <= 1'b0;
      mult_high   <= 1'b0;
      mult_signed <= 1'b0;
      mult_rd     <= '0;
      mult_index  <= '0;
    end else if (issue_flush || !ctrl.mult_ena) begin
      mult_ena    <= 1'b0;
      mult_high   <= 1'b0;
      mult_signed <= 1'b0;
      mult_rd     <= '0;
      mult_index  <= '0;
    end else if (!stall_mult) begin
      mult_ena    <= 1'b1;
      mult_high   <= ctrl.mult_high;
      mult_signed <= ctrl.mult_signed;
      mult_rd     <= ctrl.rd;
      mult_index  <= cb_tail;
    end
  end

  // Load/store unit fields
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ls_ena       <= 1'b0;
      ls_dren      <= 1'b0;
      ls_dwen      <= 1'b0;
      ls_load_type <= '0;
      ls_rd        <= '0;
      ls_index     <= '0;
      store_data   <= '0;
    end else if (issue_flush || !ctrl.ls_ena) begin
      ls_ena       <= 1'b0;
      ls_dren      <= 1'b0;
      ls_dwen      <= 1'b0;
      ls_load_type <= '0;
      ls_rd        <= '0;
      ls_index     <= '0;
      store_data   <= '0;
    end else if (!stall_ls) begin
      ls_ena       <= 1'b1;
      ls_dren      <= ctrl.dren;
      ls_dwen      <= ctrl.dwen;
      ls_load_type <= ctrl.load_type;
      ls_rd        <= ctrl.rd;
      ls_index     <= cb_tail;
      store_data   <= rs2_data;
    end
  end

  // Operands and pc follow the execute stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_port_a  <= '0;
      ex_port_b  <= '0;
      ex_pc      <= '0;
      ex_fu_type <= decode_ctrl_pkg::ARITH;
    end else if (issue_flush) begin
      ex_port_a  <= '0;
      ex_port_b  <= '0;
      ex_pc      <= '0;
      ex_fu_type <= decode_ctrl_pkg::ARITH;
    end else if (!stall_ex) begin
      ex_port_a  <= port_a;
      ex_port_b  <= port_b;
      ex_pc      <= pc;
      ex_fu_type <= ctrl.fu_type;
    end
  end

  // Halt only goes down once no unit is stalled
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt_instr <= 1'b0;
    end else if (issue_flush || any_unit_stall) begin
      halt_instr <= 1'b0;
    end else begin
      halt_instr <= ctrl.halt;
    end
  end

endmodule

/* design/ooo_decode_stage.sv */
`timescale 1ns/1ps
`include "rv32_decode_params.svh"

module ooo_decode_stage (
  input  logic                        CLK,
  input  logic                        nRST,
  input  rv32_isa_pkg::word_t         instr,
  input  rv32_isa_pkg::word_t         pc,
  input  rv32_isa_pkg::word_t         rs1_data,
  input  rv32_isa_pkg::word_t         rs2_data,
  input  logic                        pc_en,
  input  logic                        iflush_done,
  input  logic                        dflush_done,
  input  logic                        flush,
  input  logic                        stall_fetch_decode,
  input  logic                        stall_ex,
  input  logic                        stall_arith,
  input  logic                        stall_mult,
  input  logic                        stall_ls,
  input  decode_ctrl_pkg::cb_index_t  cb_tail,
  // Register file
  output rv32_isa_pkg::reg_idx_t      rf_rs1, rf_rs2, rf_rd,
  output logic                        rf_rden,
  // Cache flush
  output logic                        icache_flush, dcache_flush,
  output logic                        iflushed, dflushed,
  // Arithmetic unit
  output logic                        arith_ena,
  output decode_ctrl_pkg::alu_op_t    alu_op,
  output logic                        arith_wen,
  output rv32_isa_pkg::reg_idx_t      arith_rd,
  output decode_ctrl_pkg::cb_index_t  arith_index,
  output rv32_isa_pkg::word_t         ex_wdata,
  output logic                        jump_instr,
  output rv32_isa_pkg::word_t         ex_j_base, ex_j_offset,
  // Multiply unit
  output logic                        mult_ena, mult_high, mult_signed,
  output rv32_isa_pkg::reg_idx_t      mult_rd,
  output decode_ctrl_pkg::cb_index_t  mult_index,
  // Load/store unit
  output logic                        ls_ena, ls_dren, ls_dwen,
  output rv32_isa_pkg::load_type_t    ls_load_type,
  output rv32_isa_pkg::reg_idx_t      ls_rd,
  output decode_ctrl_pkg::cb_index_t  ls_index,
  output rv32_isa_pkg::word_t         store_data,
  // Shared
  output rv32_isa_pkg::word_t         ex_port_a, ex_port_b, ex_pc,
  output decode_ctrl_pkg::fu_type_e   ex_fu_type,
  output logic                        halt_instr,
  output logic                        busy_decode
);

  decode_ctrl_if ctrl ();

  rv32_isa_pkg::word_t port_a, port_b, wdata, j_base, j_offset;

  // Register file reads happen in the decode cycle
  assign rf_rs1  = ctrl.rs1;
  assign rf_rs2  = ctrl.rs2;
  assign rf_rd   = ctrl.rd;
  assign rf_rden = ctrl.wen;

  instr_decoder u_decoder (
    .instr (instr),
    .ctrl  (ctrl.decoder)
  );

  operand_select u_operands (
    .ctrl (ctrl.operands),
    .*
  );

  fence_tracker u_fence (
    .ctrl (ctrl.fence),
    .*
  );

  issue_latch u_issue (
    .ctrl (ctrl.latch),
    .*
  );

endmodule

/* dv/tb_ooo_decode_stage.sv */
`timescale 1ns/1ps
`include "rv32_decode_params.svh"

module tb_ooo_decode_stage;

  // About 30 cycles of tests, with ample margin
  localparam int MAX_CYCLES = 400;

  localparam rv32_isa_pkg::word_t ADDI_INSTR  = 32'hFFD3_0293;  // addi x5, x6, -3
  localparam rv32_isa_pkg::word_t ADD_INSTR   = 32'h0094_03B3;  // add x7, x8, x9
  localparam rv32_isa_pkg::word_t LUI_INSTR   = 32'h1234_5537;  // lui x10, 0x12345
  localparam rv32_isa_pkg::word_t AUIPC_INSTR = 32'h0000_1597;  // auipc x11, 1
  localparam rv32_isa_pkg::word_t JAL_INSTR   = 32'h0100_00EF;  // jal x1, +16
  localparam rv32_isa_pkg::word_t JALR_INSTR  = 32'h0081_00E7;  // jalr x1, 8(x2)
  localparam rv32_isa_pkg::word_t MUL_INSTR   = 32'h02E6_8633;  // mul x12, x13, x14
  localparam rv32_isa_pkg::word_t MUL_B_INSTR = 32'h02E6_8A33;  // mul x20, x13, x14
  localparam rv32_isa_pkg::word_t LW_INSTR    = 32'h0048_2783;  // lw x15, 4(x16)
  localparam rv32_isa_pkg::word_t SW_INSTR    = 32'h0119_2423;  // sw x17, 8(x18)
  localparam rv32_isa_pkg::word_t FENCEI      = 32'h0000_100F;
  // Plain FENCE selects no unit
  localparam rv32_isa_pkg::word_t IDLE_INSTR  = 32'h0000_000F;

  logic CLK, nRST;
  rv32_isa_pkg::word_t instr, pc, rs1_data, rs2_data;
  logic pc_en, iflush_done, dflush_done;
  logic flush, stall_fetch_decode, stall_ex, stall_arith, stall_mult, stall_ls;
  decode_ctrl_pkg::cb_index_t cb_tail;

  rv32_isa_pkg::reg_idx_t rf_rs1, rf_rs2, rf_rd;
  logic rf_rden, icache_flush, dcache_flush, iflushed, dflushed;
  logic arith_ena, arith_wen, jump_instr;
  decode_ctrl_pkg::alu_op_t alu_op;
  rv32_isa_pkg::reg_idx_t arith_rd, mult_rd, ls_rd;
  decode_ctrl_pkg::cb_index_t arith_index, mult_index, ls_index;
  rv32_isa_pkg::word_t ex_wdata, ex_j_base, ex_j_offset, store_data;
  logic mult_ena, mult_high, mult_signed, ls_ena, ls_dren, ls_dwen;
  rv32_isa_pkg::load_type_t ls_load_type;
  rv32_isa_pkg::word_t ex_port_a, ex_port_b, ex_pc;
  decode_ctrl_pkg::fu_type_e ex_fu_type;
  logic halt_instr, busy_decode;

  integer seed;
  int cycle_count = 0;

  ooo_decode_stage UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      abort_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input rv32_isa_pkg::word_t got,
                            input rv32_isa_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_idx(input string name, input rv32_isa_pkg::reg_idx_t got,
                           input rv32_isa_pkg::reg_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_cb(input string name, input decode_ctrl_pkg::cb_index_t got,
                          input decode_ctrl_pkg::cb_index_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_fu(input string name, input decode_ctrl_pkg::fu_type_e got,
                          input decode_ctrl_pkg::fu_type_e exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_alu_op(input string name, input decode_ctrl_pkg::alu_op_t got,
                              input decode_ctrl_pkg::alu_op_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_load_type(input string name, input rv32_isa_pkg::load_type_t got,
                                 input rv32_isa_pkg::load_type_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  // Immediates as the RV32 spec lays them out
  function automatic rv32_isa_pkg::word_t i_imm_of(input rv32_isa_pkg::word_t w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic rv32_isa_pkg::word_t s_imm_of(input rv32_isa_pkg::word_t w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
  endfunction

  function automatic rv32_isa_pkg::word_t u_imm_of(input rv32_isa_pkg::word_t w);
    return {w[31:12], 12'b0};
  endfunction

  function automatic rv32_isa_pkg::word_t j_imm_of(input rv32_isa_pkg::word_t w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  // Called at a falling edge, new operands and tail index with every word
  task automatic present_instr(input rv32_isa_pkg::word_t word);
    instr    = word;
    rs1_data = $random(seed);
    rs2_data = $random(seed);
    pc       = pc + 32'd4;
    cb_tail  = cb_tail + 1'b1;
    #1;
  endtask

  task automatic next_negedge();
    @(negedge CLK);
  endtask

  task automatic check_rf_indices();
    check_idx("rf_rs1", rf_rs1, instr[19:15]);
    check_idx("rf_rs2", rf_rs2, instr[24:20]);
    check_idx("rf_rd", rf_rd, instr[11:7]);
  endtask

  task automatic check_reset_state();
    check_bit("arith_ena", arith_ena, 1'b0);
    check_bit("mult_ena", mult_ena, 1'b0);
    check_bit("ls_ena", ls_ena, 1'b0);
    check_bit("icache_flush", icache_flush, 1'b0);
    check_bit("iflushed", iflushed, 1'b1);
    check_bit("dflushed", dflushed, 1'b1);
  endtask

  task automatic test_alu_ops();
    present_instr(ADDI_INSTR);
    check_rf_indices();
    check_bit("rf_rden", rf_rden, 1'b1);
    next_negedge();
    check_bit("arith_ena", arith_ena, 1'b1);
    check_bit("arith_wen", arith_wen, 1'b1);
    check_cb("arith_index", arith_index, cb_tail);
    check_idx("arith_rd", arith_rd, instr[11:7]);
    // Bit 30 is set in this immediate but ADDI has no second form
    check_alu_op("alu_op", alu_op, {1'b0, instr[14:12]});
    check_word("ex_port_a", ex_port_a, rs1_data);
    check_word("ex_port_b", ex_port_b, i_imm_of(instr));
    check_word("ex_pc", ex_pc, pc);
    check_fu("ex_fu_type", ex_fu_type, decode_ctrl_pkg::ARITH);
    present_instr(ADD_INSTR);
    check_rf_indices();
    next_negedge();
    check_bit("arith_ena", arith_ena, 1'b1);
    check_cb("arith_index", arith_index, cb_tail);
    check_alu_op("alu_op", alu_op, {instr[30], instr[14:12]});
    check_word("ex_port_a", ex_port_a, rs1_data);
    check_word("ex_port_b", ex_port_b, rs2_data);
  endtask

  task automatic test_upper_and_jumps();
    present_instr(LUI_INSTR);
    next_negedge();
    check_word("ex_wdata", ex_wdata, u_imm_of(instr));
    present_instr(AUIPC_INSTR);
    next_negedge();
    check_word("ex_port_a", ex_port_a, pc);
    check_word("ex_port_b", ex_port_b, u_imm_of(instr));
    present_instr(JAL_INSTR);
    next_negedge();
    check_bit("jump_instr", jump_instr, 1'b1);
    check_word("ex_wdata", ex_wdata, pc + 32'd4);
    check_word("ex_j_base", ex_j_base, pc);
    check_word("ex_j_offset", ex_j_offset, j_imm_of(instr));
    present_instr(JALR_INSTR);
    next_negedge();
    check_word("ex_wdata", ex_wdata, pc + 32'd4);
    check_word("ex_j_base", ex_j_base, rs1_data);
    check_word("ex_j_offset", ex_j_offset, i_imm_of(instr));
  endtask

  task automatic test_unit_routing();
    present_instr(MUL_INSTR);
    next_negedge();
    check_bit("mult_ena", mult_ena, 1'b1);
    // Plain MUL is the signed low half
    check_bit("mult_high", mult_high, 1'b0);
    check_bit("mult_signed", mult_signed, 1'b1);
    check_idx("mult_rd", mult_rd, instr[11:7]);
    check_cb("mult_index", mult_index, cb_tail);
    check_bit("arith_ena", arith_ena, 1'b0);
    check_bit("ls_ena", ls_ena, 1'b0);
    check_fu("ex_fu_type", ex_fu_type, decode_ctrl_pkg::MULT);
    present_instr(LW_INSTR);
    next_negedge();
    check_bit("ls_ena", ls_ena, 1'b1);
    check_bit("ls_dren", ls_dren, 1'b1);
    check_load_type("ls_load_type", ls_load_type, instr[14:12]);
    check_idx("ls_rd", ls_rd, instr[11:7]);
    check_cb("ls_index", ls_index, cb_tail);
    check_word("ex_port_b", ex_port_b, i_imm_of(instr));
    check_bit("mult_ena", mult_ena, 1'b0);
    check_bit("arith_ena", arith_ena, 1'b0);
    present_instr(SW_INSTR);
    next_negedge();
    check_bit("ls_dwen", ls_dwen, 1'b1);
    check_bit("ls_dren", ls_dren, 1'b0);
    check_word("store_data", store_data, rs2_data);
    check_word("ex_port_b", ex_port_b, s_imm_of(instr));
    check_fu("ex_fu_type", ex_fu_type, decode_ctrl_pkg::LOADSTORE);
  endtask

  task automatic test_stall_flush();
    rv32_isa_pkg::reg_idx_t held_rd;
    decode_ctrl_pkg::cb_index_t held_index;
    present_instr(MUL_INSTR);
    next_negedge();
    held_rd    = instr[11:7];
    held_index = cb_tail;
    stall_mult = 1'b1;
    present_instr(MUL_B_INSTR);
    next_negedge();
    check_bit("mult_ena", mult_ena, 1'b1);
    check_idx("mult_rd", mult_rd, held_rd);
    check_cb("mult_index", mult_index, held_index);
    stall_mult = 1'b0;
    present_instr(ADD_INSTR);
    next_negedge();
    check_bit("arith_ena", arith_ena, 1'b1);
    flush = 1'b1;
    present_instr(LW_INSTR);
    next_negedge();
    check_bit("arith_ena", arith_ena, 1'b0);
    check_bit("mult_ena", mult_ena, 1'b0);
    check_bit("ls_ena", ls_ena, 1'b0);
    check_fu("ex_fu_type", ex_fu_type, decode_ctrl_pkg::ARITH);
    flush = 1'b0;
  endtask

  task automatic test_fence();
    present_instr(FENCEI);
    check_bit("icache_flush", icache_flush, 1'b1);
    check_bit("dcache_flush", dcache_flush, 1'b1);
    next_negedge();
    // Second FENCE.I in a row must not pulse again
    present_instr(FENCEI);
    check_bit("icache_flush", icache_flush, 1'b0);
    check_bit("dcache_flush", dcache_flush, 1'b0);
    check_bit("iflushed", iflushed, 1'b0);
    check_bit("dflushed", dflushed, 1'b0);
    next_negedge();
    iflush_done = 1'b1;
    present_instr(IDLE_INSTR);
    next_negedge();
    check_bit("iflushed", iflushed, 1'b1);
    check_bit("dflushed", dflushed, 1'b0);
    iflush_done = 1'b0;
    dflush_done = 1'b1;
    pc_en       = 1'b0;
    next_negedge();
    check_bit("dflushed", dflushed, 1'b0);
    pc_en = 1'b1;
    next_negedge();
    check_bit("dflushed", dflushed, 1'b1);
    dflush_done = 1'b0;
  endtask

  task automatic test_halt();
    present_instr(`HALT_WORD);
    next_negedge();
    check_bit("halt_instr", halt_instr, 1'b1);
    stall_ls = 1'b1;
    present_instr(`HALT_WORD);
    check_bit("busy_decode", busy_decode, 1'b1);
    next_negedge();
    check_bit("halt_instr", halt_instr, 1'b0);
    stall_ls = 1'b0;
  endtask

  initial begin
    seed               = 60776;
    nRST               = 1'b0;
    instr              = IDLE_INSTR;
    pc                 = 32'h0000_1000;
    rs1_data           = '0;
    rs2_data           = '0;
    pc_en              = 1'b1;
    iflush_done        = 1'b0;
    dflush_done        = 1'b0;
    flush              = 1'b0;
    stall_fetch_decode = 1'b0;
    stall_ex           = 1'b0;
    stall_arith        = 1'b0;
    stall_mult         = 1'b0;
    stall_ls           = 1'b0;
    cb_tail            = '0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    #1;
    check_reset_state();
    next_negedge();
    test_alu_ops();
    test_upper_and_jumps();
    test_unit_routing();
    test_stall_flush();
    test_fence();
    test_halt();
    $display("Testbench passed");
    $finish;
  end

endmodule

/* ooo_decode_stage.f */
+incdir+design
design/rv32_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/decode_ctrl_if.sv
design/instr_decoder.sv
design/operand_select.sv
design/fence_tracker.sv
design/issue_latch.sv
design/ooo_decode_stage.sv
dv/tb_ooo_decode_stage.sv
